/* rtl/fpuCsr.sv */
/*
 * rounding mode and FPU status register
 */
`timescale 1ns/1ns

module fpuCsr
  import fpuCtrlPkg::*;
(
  input  logic  clk,
  input  logic  arstN,
  input  logic  csrWe,      // write strobe
  input  fpCsrS csrWrData,
  output fpCsrS csrQ
);

  fpCsrS csrR;

  // both fields load together, visible the cycle after the write edge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      csrR.frm <= 3'd0;       // round to nearest even
      csrR.fs  <= 2'd3;       // FPU on, dirty
    end else if (csrWe) begin
      csrR <= csrWrData;
    end
  end

  assign csrQ = csrR;

  // 5 and 6 are reserved, the dynamic mode would leak them into frmD
  aFrmReserved: assert property (@(posedge clk) disable iff (!arstN)
    csrWe |=> !(csrQ.frm inside {3'd5, 3'd6}))
    else $error("reserved rounding mode %0d written", csrQ.frm);

endmodule

/* rtl/fpuCtrl.sv */
/*
 * FP control unit top level
 * CSR, decoder, operand select and stage registers
 */
`timescale 1ns/1ns

module fpuCtrl (
  input  logic                   clk,
  input  logic                   arstN,
  input  fpuCtrlPkg::fpInstrU    instrD,
  input  fpuCtrlPkg::stageStallS stall,
  input  fpuCtrlPkg::stageFlushS flush,
  input  logic                   divBusyE,
  input  logic                   csrWe,
  input  fpuCtrlPkg::fpCsrS      csrWrData,
  output fpuCtrlPkg::fpOpndS     opndD,
  output fpuCtrlPkg::fpStageS    stageE,
  output fpuCtrlPkg::fpOpndS     opndE,
  output logic                   divStartE,
  output fpuCtrlPkg::fpStageS    stageM,
  output fpuCtrlPkg::fpWbS       wbW
);

  fpuCtrlPkg::fpCsrS  csrQ;
  fpuCtrlPkg::fpCtrlS ctrlD;
  logic [2:0]         frmD;
  logic               fmtD;

  fpuCsr csr_i (
    .clk       (clk),
    .arstN     (arstN),
    .csrWe     (csrWe),
    .csrWrData (csrWrData),
    .csrQ      (csrQ)
  );

  fpuDecoder decoder_i (
    .instrD   (instrD),
    .fsStatus (csrQ.fs),
    .ctrlD    (ctrlD)
  );

  fpuOperandSel operandSel_i (
    .instrD (instrD),
    .ctrlD  (ctrlD),
    .frmCsr (csrQ.frm),
    .opndD  (opndD),
    .frmD   (frmD),
    .fmtD   (fmtD)
  );

  fpuCtrlPipe pipe_i (
    .clk       (clk),
    .arstN     (arstN),
    .stall     (stall),
    .flush     (flush),
    .divBusyE  (divBusyE),
    .ctrlD     (ctrlD),
    .opndD     (opndD),
    .frmD      (frmD),
    .fmtD      (fmtD),
    .stageE    (stageE),
    .opndE     (opndE),
    .divStartE (divStartE),
    .stageM    (stageM),
    .wbW       (wbW)
  );

endmodule

/* rtl/fpuCtrlPipe.sv */
/*
 * Execute, Memory and Writeback control registers
 * per-stage stall and flush, divide start held while the divider is busy
 */
`timescale 1ns/1ns

module fpuCtrlPipe
  import fpuCtrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  stageStallS stall,
  input  stageFlushS flush,
  input  logic       divBusyE,   // divider still working
  input  fpCtrlS     ctrlD,
  input  fpOpndS     opndD,
  input  logic [2:0] frmD,
  input  logic       fmtD,
  output fpStageS    stageE,
  output fpOpndS     opndE,
  output logic       divStartE,
  output fpStageS    stageM,
  output fpWbS       wbW
);

  fpStageS stageD;
  fpWbS    wbM;

  // divStart leaves the payload here
  assign stageD = '{
    regWrite: ctrlD.regWrite, writeInt: ctrlD.writeInt, resSel: ctrlD.resSel,
    postSel: ctrlD.postSel, opCtrl: ctrlD.opCtrl, illegal: ctrlD.illegal,
    cvtInt: ctrlD.cvtInt, frm: frmD, fmt: fmtD
  };

  assign wbM = '{regWrite: stageM.regWrite, resSel: stageM.resSel, cvtInt: stageM.cvtInt};

  ////////////////////////////////////////////////////////////////////////////
  // stage registers, flush beats stall

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stageE <= '0;
      opndE  <= '0;
    end else if (flush.e) begin
      stageE <= '0;  // bubble
      opndE  <= '0;
    end else if (!stall.e) begin
      stageE <= stageD;
      opndE  <= opndD;
    end
  end

  // keeps sampling while busy so the start re-fires after a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)                      divStartE <= 1'b0;
    else if (flush.e)                divStartE <= 1'b0;
    else if (!stall.e || divBusyE)   divStartE <= ctrlD.divStart;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)         stageM <= '0;
    else if (flush.m)   stageM <= '0;
    else if (!stall.m)  stageM <= stageE;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)         wbW <= '0;
    else if (flush.w)   wbW <= '0;
    else if (!stall.w)  wbW <= wbM;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  aFlushE: assert property (@(posedge clk) disable iff (!arstN)
    flush.e |=> !stageE.regWrite && !divStartE);
  aFlushM: assert property (@(posedge clk) disable iff (!arstN)
    flush.m |=> !stageM.regWrite);
  aFlushW: assert property (@(posedge clk) disable iff (!arstN)
    flush.w |=> !wbW.regWrite);

  // the decoder never marks an illegal word as writing
  aIllegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
    !(stageM.illegal && stageM.regWrite))
    else $error("illegal instruction with regWrite in Memory");

endmodule

/* rtl/fpuCtrlPkg.sv */
/*
 * types for the FP control unit
 * instruction word union, control/operand/stage structs, CSR and flow control
 */
package fpuCtrlPkg;

  `include "fpu_defines.svh"

  ////////////////////////////////////////////////////////////////////////////
  // instruction word

  typedef struct packed {
    logic [6:0]          funct7;
    logic [`regAdrW-1:0] rs2;
    logic [`regAdrW-1:0] rs1;
    logic [2:0]          funct3;   // rounding mode or width
    logic [`regAdrW-1:0] rd;
    logic [6:0]          opcode;
  } rTypeS;

  typedef struct packed {
    logic [`regAdrW-1:0] rs3;      // fma addend
    logic [1:0]          fmt;      // 2 and 3 illegal here
    logic [`regAdrW-1:0] rs2;
    logic [`regAdrW-1:0] rs1;
    logic [2:0]          funct3;
    logic [`regAdrW-1:0] rd;
    logic [6:0]          opcode;
  } r4TypeS;

  typedef union packed {
    rTypeS  rType;                 // funct7 view
    r4TypeS r4Type;                // rs3 / fmt view
  } fpInstrU;

  ////////////////////////////////////////////////////////////////////////////
  // control words

  // final result, fp dest / int dest
  typedef enum logic [1:0] {
    resOther = 2'd0,               // sgnj, min/max, fmv.w.x | compare
    resPost  = 2'd1,               // post processing | fp->int cvt
    resStore = 2'd2,               // load, store | class
    resMove  = 2'd3                // fmv.x.w
  } resSelE;

  typedef enum logic [1:0] {
    postCvt = 2'd0,
    postDiv = 2'd1,
    postFma = 2'd2
  } postSelE;

  typedef struct packed {
    logic                regWrite;  // fp reg write
    logic                writeInt;  // int reg write
    resSelE              resSel;
    postSelE             postSel;
    logic [`opCtrlW-1:0] opCtrl;
    logic                divStart;
    logic                illegal;
    logic                cvtInt;
  } fpCtrlS;

  typedef struct packed {
    logic [`regAdrW-1:0] adr1;
    logic [`regAdrW-1:0] adr2;
    logic [`regAdrW-1:0] adr3;
    logic                xEn;
    logic                yEn;
    logic                zEn;
  } fpOpndS;

  // stage payload, divStart travels on its own flop
  typedef struct packed {
    logic                regWrite;
    logic                writeInt;
    resSelE              resSel;
    postSelE             postSel;
    logic [`opCtrlW-1:0] opCtrl;
    logic                illegal;
    logic                cvtInt;
    logic [2:0]          frm;
    logic [`fmtW-1:0]    fmt;
  } fpStageS;

  typedef struct packed {
    logic                regWrite;
    resSelE              resSel;
    logic                cvtInt;
  } fpWbS;

  typedef struct packed {
    logic [2:0] frm;               // dynamic rounding mode
    logic [1:0] fs;                // 0 = FPU off
  } fpCsrS;

  typedef struct packed {
    logic e;
    logic m;
    logic w;
  } stageStallS;

  typedef struct packed {
    logic e;
    logic m;
    logic w;
  } stageFlushS;

endpackage

/* rtl/fpuDecoder.sv */
/*
 * Decode-stage FP control word
 * opcode / funct7 / funct3 decode with FPU-off and format legality checks
 */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpuDecoder
  import fpuCtrlPkg::*;
(
  input  fpInstrU    instrD,
  input  logic [1:0] fsStatus,   // from fpuCsr
  output fpCtrlS     ctrlD
);

  localparam fpCtrlS illegalWord = '{
    regWrite: 1'b0, writeInt: 1'b0, resSel: resOther, postSel: postCvt,
    opCtrl: '0, divStart: 1'b0, illegal: 1'b1, cvtInt: 1'b0
  };

  // pack one legal control word
  function automatic fpCtrlS ctl(input logic rw, input logic wi, input resSelE rs,
                                 input postSelE ps, input logic [`opCtrlW-1:0] oc,
                                 input logic ds, input logic ci);
    fpCtrlS c;
    c.regWrite = rw;
    c.writeInt = wi;
    c.resSel   = rs;
    c.postSel  = ps;
    c.opCtrl   = oc;
    c.divStart = ds;
    c.illegal  = 1'b0;
    c.cvtInt   = ci;
    return c;
  endfunction

  logic [6:0]          op;
  logic [2:0]          f3;
  logic [4:0]          f7Hi;     // funct7 without fmt
  logic [1:0]          cvtSel;   // rs2 low bits, int width and sign
  logic [1:0]          fmt;
  logic                fpuOn;
  logic                memOp;
  logic                fmtOk;
  logic [`opCtrlW-1:0] cvtCode;  // {int->fp, 64 bit, signed}

  assign op     = instrD.rType.opcode;
  assign f3     = instrD.rType.funct3;
  assign f7Hi   = instrD.rType.funct7[6:2];
  assign cvtSel = instrD.rType.rs2[1:0];
  assign fmt    = instrD.r4Type.fmt;

  assign fpuOn = (fsStatus != 2'b00);
  assign memOp = (op == `opcLoadFp) || (op == `opcStoreFp);  // width sits in funct3
  assign fmtOk = (fmt == 2'b00) || ((fmt == 2'b01) && `dSupported);

  // w 101/001, wu 100/000, l 111/011, lu 110/010
  assign cvtCode = {1'b0, cvtSel[1], ~cvtSel[0]};

  always_comb begin
    ctrlD = illegalWord;  // anything not matched below
    if (fpuOn && (memOp || fmtOk)) begin
      case (op)
        `opcLoadFp: case (f3)
          3'b010: ctrlD = ctl(1'b1, 1'b0, resStore, postCvt, 3'd0, 1'b0, 1'b0); // flw
          3'b011: if (`dSupported)
                    ctrlD = ctl(1'b1, 1'b0, resStore, postCvt, 3'd0, 1'b0, 1'b0); // fld
          default: ;
        endcase
        `opcStoreFp: case (f3)
          3'b010: ctrlD = ctl(1'b0, 1'b0, resStore, postCvt, 3'd0, 1'b0, 1'b0); // fsw
          3'b011: if (`dSupported)
                    ctrlD = ctl(1'b0, 1'b0, resStore, postCvt, 3'd0, 1'b0, 1'b0); // fsd
          default: ;
        endcase
        // fused ops, opCtrl = {0, negate prod, negate addend}
        `opcMadd:  ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd0, 1'b0, 1'b0);
        `opcMsub:  ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd1, 1'b0, 1'b0);
        `opcNmsub: ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd2, 1'b0, 1'b0);
        `opcNmadd: ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd3, 1'b0, 1'b0);
        `opcOpFp: case (f7Hi)
          5'b00000: ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd6, 1'b0, 1'b0); // fadd
          5'b00001: ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd7, 1'b0, 1'b0); // fsub
          5'b00010: ctrlD = ctl(1'b1, 1'b0, resPost, postFma, 3'd4, 1'b0, 1'b0); // fmul
          5'b00011: ctrlD = ctl(1'b1, 1'b0, resPost, postDiv, 3'd0, 1'b1, 1'b0); // fdiv
          5'b01011: ctrlD = ctl(1'b1, 1'b0, resPost, postDiv, 3'd1, 1'b1, 1'b0); // fsqrt
          5'b00100: case (f3)  // sign inject
            3'b000: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd0, 1'b0, 1'b0);
            3'b001: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd1, 1'b0, 1'b0); // negate
            3'b010: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd2, 1'b0, 1'b0); // xor
            default: ;
          endcase
          5'b00101: case (f3)
            3'b000: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd6, 1'b0, 1'b0); // fmin
            3'b001: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd5, 1'b0, 1'b0); // fmax
            default: ;
          endcase
          5'b10100: case (f3)  // compares land in the int file
            3'b010: ctrlD = ctl(1'b0, 1'b1, resOther, postCvt, 3'd2, 1'b0, 1'b0); // feq
            3'b001: ctrlD = ctl(1'b0, 1'b1, resOther, postCvt, 3'd1, 1'b0, 1'b0); // flt
            3'b000: ctrlD = ctl(1'b0, 1'b1, resOther, postCvt, 3'd3, 1'b0, 1'b0); // fle
            default: ;
          endcase
          5'b11100: case (f3)
            3'b000: ctrlD = ctl(1'b0, 1'b1, resMove, postCvt, 3'd0, 1'b0, 1'b0);  // fmv.x.w
            3'b001: ctrlD = ctl(1'b0, 1'b1, resStore, postCvt, 3'd0, 1'b0, 1'b0); // fclass
            default: ;
          endcase
          5'b11110: ctrlD = ctl(1'b1, 1'b0, resOther, postCvt, 3'd3, 1'b0, 1'b0); // fmv.w.x
          // int -> fp, top opCtrl bit set
          5'b11010: ctrlD = ctl(1'b1, 1'b0, resPost, postCvt, cvtCode | 3'b100, 1'b0, 1'b0);
          // fp -> int
          5'b11000: ctrlD = ctl(1'b0, 1'b1, resPost, postCvt, cvtCode, 1'b0, 1'b1);
          // single <-> double, opCtrl carries the destination format
          5'b01000: ctrlD = ctl(1'b1, 1'b0, resPost, postCvt, {2'b00, fmt[0]}, 1'b0, 1'b0);
          default: ;
        endcase
        default: ;
      endcase
    end
  end

endmodule

/* rtl/fpuOperandSel.sv */
/*
 * Decode-stage rounding mode, precision, source addresses and operand enables
 */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpuOperandSel
  import fpuCtrlPkg::*;
(
  input  fpInstrU    instrD,
  input  fpCtrlS     ctrlD,
  input  logic [2:0] frmCsr,     // dynamic mode from fpuCsr
  output fpOpndS     opndD,
  output logic [2:0] frmD,
  output logic       fmtD
);

  logic [2:0] f3;
  logic       isOpFp;
  logic       isMem;
  logic       isFpCvt;    // fcvt.s.d / fcvt.d.s
  logic       mvToFp;     // fmv.w.x, coded as resOther with opCtrl 3
  logic       cvtOp;

  assign f3      = instrD.rType.funct3;
  assign isOpFp  = (instrD.rType.opcode == `opcOpFp);
  assign isMem   = (instrD.rType.opcode == `opcLoadFp) || (instrD.rType.opcode == `opcStoreFp);
  assign isFpCvt = isOpFp && (instrD.rType.funct7[6:2] == 5'b01000);

  // 111 picks the CSR, 000..100 are static modes
  assign frmD = (f3 == 3'b111) ? frmCsr : f3;

  // precision, 0 single / 1 double
  always_comb begin
    if (isFpCvt)    fmtD = instrD.rType.rs2[0];     // source format
    else if (isMem) fmtD = f3[0];                   // 010 w, 011 d
    else            fmtD = instrD.r4Type.fmt[0];
  end

  assign opndD.adr1 = instrD.rType.rs1;
  assign opndD.adr2 = instrD.rType.rs2;
  assign opndD.adr3 = instrD.r4Type.rs3;

  assign mvToFp = (ctrlD.resSel == resOther) && ctrlD.regWrite && (ctrlD.opCtrl == 3'd3);
  assign cvtOp  = (ctrlD.resSel == resPost) && (ctrlD.postSel == postCvt);

  // x unused by load/store, mv int->fp and int->fp cvt
  assign opndD.xEn = !(((ctrlD.resSel == resStore) && !ctrlD.writeInt) ||
                       mvToFp ||
                       (cvtOp && ctrlD.opCtrl[2]));

  // y unused by load, class, moves, all cvts and sqrt
  assign opndD.yEn = !(((ctrlD.resSel == resStore) && (ctrlD.writeInt || ctrlD.regWrite)) ||
                       (ctrlD.resSel == resMove) || mvToFp || cvtOp ||
                       ((ctrlD.resSel == resPost) && (ctrlD.postSel == postDiv) &&
                        ctrlD.opCtrl[0]));

  // z only for the fma family, add and sub (not mul)
  assign opndD.zEn = (ctrlD.resSel == resPost) && (ctrlD.postSel == postFma) &&
                     (!ctrlD.opCtrl[2] || ctrlD.opCtrl[1]);

  // every op with an addend also reads x
  always_comb begin
    aZImpliesX: assert final (!opndD.zEn || opndD.xEn)
      else $error("zEn without xEn, instr %h", instrD);
  end

endmodule

/* rtl/fpu_defines.svh */
/*
 * FP control unit macros
 * major opcodes, field widths and feature switches
 */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// feature switches
`define dSupported 1'b1             // double precision present

// major opcodes, bits 6:0
`define opcLoadFp  7'b0000111       // flw / fld
`define opcStoreFp 7'b0100111       // fsw / fsd
`define opcMadd    7'b1000011
`define opcMsub    7'b1000111
`define opcNmsub   7'b1001011
`define opcNmadd   7'b1001111
`define opcOpFp    7'b1010011       // all two-operand and unary ops

// field widths
`define fmtW    1                   // 0 single, 1 double
`define regAdrW 5
`define opCtrlW 3

`endif

/* src.f */
+incdir+rtl
+incdir+verification
rtl/fpuCtrlPkg.sv
rtl/fpuCsr.sv
rtl/fpuDecoder.sv
rtl/fpuOperandSel.sv
rtl/fpuCtrlPipe.sv
rtl/fpuCtrl.sv
verification/tbClock.sv
verification/fpuCtrlTb.sv

/* verification/fpuCtrlRef.svh */
/*
 * instruction encoder for the FP control unit testbench
 * expected stage payload, operand select and divide start per instruction class
 */
`ifndef FPU_CTRL_REF_SVH
`define FPU_CTRL_REF_SVH

// hi is rs3 for fused ops, funct7[6:2] otherwise
function automatic logic [31:0] encodeInstr(input logic [4:0] hi, input logic [1:0] fmt,
                                            input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [6:0] opc);
  return {hi, fmt, rs2, rs1, f3, 5'd9, opc};  // rd not used by the unit
endfunction

function automatic void refDecode(input logic [31:0] w, input logic [1:0] fs,
                                  input logic [2:0] dynFrm, output fpStageS st,
                                  output fpOpndS op, output logic ds);
  logic [6:0]  opc;
  logic [4:0]  hi;
  logic [2:0]  f3;
  logic [1:0]  fmt;
  logic [4:0]  rs2;
  logic        mem;
  logic        ok;
  logic        fmtBit;
  logic [2:0]  frm;
  logic [13:0] e;   // divStart, cvtInt, rw, wi, resSel, postSel, opCtrl, x, y, z
  opc = w[6:0];
  f3  = w[14:12];
  rs2 = w[24:20];
  fmt = w[26:25];
  hi  = w[31:27];
  mem = (opc == `opcLoadFp) || (opc == `opcStoreFp);
  ok  = 1'b1;
  e   = {2'b00, 9'd0, 3'b110};
  case (opc)
    `opcLoadFp: begin
      ok = (f3 == 3'd2) || ((f3 == 3'd3) && `dSupported);
      e  = {2'b00, 2'b10, resStore, postCvt, 3'd0, 3'b000};
    end
    `opcStoreFp: begin
      ok = (f3 == 3'd2) || ((f3 == 3'd3) && `dSupported);
      e  = {2'b00, 2'b00, resStore, postCvt, 3'd0, 3'b010};   // y carries store data
    end
    `opcMadd, `opcMsub, `opcNmsub, `opcNmadd:
      e = {2'b00, 2'b10, resPost, postFma, 1'b0, opc[3:2], 3'b111};  // madd 0 .. nmadd 3
    `opcOpFp: case (hi)
      5'b00000: e = {2'b00, 2'b10, resPost, postFma, 3'd6, 3'b111};  // fadd
      5'b00001: e = {2'b00, 2'b10, resPost, postFma, 3'd7, 3'b111};  // fsub
      5'b00010: e = {2'b00, 2'b10, resPost, postFma, 3'd4, 3'b110};  // fmul
      5'b00011: e = {2'b10, 2'b10, resPost, postDiv, 3'd0, 3'b110};  // fdiv
      5'b01011: e = {2'b10, 2'b10, resPost, postDiv, 3'd1, 3'b100};  // fsqrt
      5'b00100: begin
        ok = (f3 <= 3'd2);
        e  = {2'b00, 2'b10, resOther, postCvt, f3, 3'b110};          // sgnj, n, x
      end
      5'b00101: begin
        ok = (f3 <= 3'd1);
        e  = {2'b00, 2'b10, resOther, postCvt, (f3 == 3'd0) ? 3'd6 : 3'd5, 3'b110};
      end
      5'b10100: begin
        ok = (f3 <= 3'd2);                                          // le 0, lt 1, eq 2
        e  = {2'b00, 2'b01, resOther, postCvt, (f3 == 3'd0) ? 3'd3 : f3, 3'b110};
      end
      5'b11100: begin
        ok = (f3 <= 3'd1);
        e  = (f3 == 3'd0) ? {2'b00, 2'b01, resMove, postCvt, 3'd0, 3'b100}
                          : {2'b00, 2'b01, resStore, postCvt, 3'd0, 3'b100};  // fclass
      end
      5'b11110: e = {2'b00, 2'b10, resOther, postCvt, 3'd3, 3'b000};  // fmv.w.x
      // rs2 bit 1 picks 64-bit ints, bit 0 unsigned
      5'b11010: e = {2'b00, 2'b10, resPost, postCvt, 1'b1, rs2[1], ~rs2[0], 3'b000};
      5'b11000: e = {2'b01, 2'b01, resPost, postCvt, 1'b0, rs2[1], ~rs2[0], 3'b100};
      5'b01000: e = {2'b00, 2'b10, resPost, postCvt, 2'b00, fmt[0], 3'b100};  // s <-> d
      default:  ok = 1'b0;
    endcase
    default: ok = 1'b0;
  endcase
  if (!mem && fmt[1])
    ok = 1'b0;                      // half / quad
  if (fs == 2'd0)
    ok = 1'b0;                      // FPU off
  if (!ok)
    e = {2'b00, 9'd0, 3'b110};
  frm    = (f3 == 3'd7) ? dynFrm : f3;
  fmtBit = ((opc == `opcOpFp) && (hi == 5'b01000)) ? rs2[0] : (mem ? f3[0] : fmt[0]);
  ds = e[13];
  st = {e[11:3], !ok, e[12], frm, fmtBit};
  op = {w[19:15], rs2, hi, e[2:0]};
endfunction

`endif

/* verification/fpuCtrlTb.sv */
/*
 * FP control unit testbench
 * directed and random instructions, stage model, per-cycle compare
 */
`timescale 1ns/1ns
`include "fpu_defines.svh"

module fpuCtrlTb
  import fpuCtrlPkg::*;
();

  logic       clk;
  logic       arstN;
  fpInstrU    instrD;
  stageStallS stall;
  stageFlushS flush;
  logic       divBusyE;
  logic       csrWe;
  fpCsrS      csrWrData;
  fpOpndS     opndD;
  fpStageS    stageE;
  fpOpndS     opndE;
  logic       divStartE;
  fpStageS    stageM;
  fpWbS       wbW;

  // model state, CSR plus one entry per stage
  fpCsrS   csrM;
  fpStageS expE;
  fpOpndS  expOpndE;
  logic    expDivE;
  fpStageS expM;
  fpWbS    expW;

  int          errors = 0;
  int          checks = 0;
  integer      seed;
  logic [31:0] legal[$];

  `include "fpuCtrlRef.svh"

  tbClock clk_i (.clk(clk), .arstN(arstN));

  fpuCtrl dut_i (
    .clk(clk), .arstN(arstN), .instrD(instrD), .stall(stall), .flush(flush),
    .divBusyE(divBusyE), .csrWe(csrWe), .csrWrData(csrWrData), .opndD(opndD),
    .stageE(stageE), .opndE(opndE), .divStartE(divStartE), .stageM(stageM), .wbW(wbW)
  );

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    errors++;
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic drive(input logic [31:0] w, input logic [2:0] stl, input logic [2:0] fl,
                       input logic busy);
    @(posedge clk);
    instrD   <= w;
    stall    <= stl;
    flush    <= fl;
    divBusyE <= busy;
    csrWe    <= 1'b0;
  endtask

  task automatic writeCsr(input logic [2:0] frm, input logic [1:0] fs);
    @(posedge clk);
    csrWe     <= 1'b1;
    csrWrData <= '{frm: frm, fs: fs};
    @(posedge clk);
    csrWe     <= 1'b0;
  endtask

  // illegal word must reach Memory two edges after it is driven
  task automatic checkLatency(input logic [31:0] w);
    int n;
    drive(w, 3'b000, 3'b000, 1'b0);
    @(negedge clk);
    n = 0;
    while (!stageM.illegal && n < 8) begin
      @(negedge clk);
      n++;
    end
    aLatency: assert (stageM.illegal && n == 2) else begin
      errors++;
      $display("FAILED %0t: illegal flag reached Memory after %0d cycles", $time, n);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stage model, same sampling edge as the DUT

  always @(posedge clk or negedge arstN) begin
    fpStageS st;
    fpOpndS  op;
    logic    ds;
    if (!arstN) begin
      csrM     <= '{frm: 3'd0, fs: 2'd3};
      expE     <= '0;
      expOpndE <= '0;
      expDivE  <= 1'b0;
      expM     <= '0;
      expW     <= '0;
    end else begin
      refDecode(instrD, csrM.fs, csrM.frm, st, op, ds);  // old CSR value
      if (csrWe)
        csrM <= csrWrData;
      if (flush.e) begin
        expE     <= '0;
        expOpndE <= '0;
      end else if (!stall.e) begin
        expE     <= st;
        expOpndE <= op;
      end
      if (flush.e)
        expDivE <= 1'b0;
      else if (!stall.e || divBusyE)
        expDivE <= ds;      // busy divider keeps sampling
      if (flush.m)
        expM <= '0;
      else if (!stall.m)
        expM <= expE;
      if (flush.w)
        expW <= '0;
      else if (!stall.w)
        expW <= '{regWrite: expM.regWrite, resSel: expM.resSel, cvtInt: expM.cvtInt};
    end
  end

  // compare mid-cycle, outputs settled
  always @(negedge clk) begin
    fpStageS st;
    fpOpndS  op;
    logic    ds;
    refDecode(instrD, csrM.fs, csrM.frm, st, op, ds);
    checks++;
    aOpndD: assert (opndD === op) else reportMismatch("opndD", opndD, op);
    aStageE: assert (stageE === expE) else reportMismatch("stageE", stageE, expE);
    aOpndE: assert (opndE === expOpndE) else reportMismatch("opndE", opndE, expOpndE);
    aDivE: assert (divStartE === expDivE) else reportMismatch("divStartE", divStartE, expDivE);
    aStageM: assert (stageM === expM) else reportMismatch("stageM", stageM, expM);
    aWbW: assert (wbW === expW) else reportMismatch("wbW", wbW, expW);
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    int          n;
    seed      = 32'h1f1f_6c78;
    instrD    = '0;
    stall     = '0;
    flush     = '0;
    divBusyE  = 1'b0;
    csrWe     = 1'b0;
    csrWrData = '0;
    n = 0;
    while (arstN !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (arstN !== 1'b1)
      abortRun("reset was never released");

    // one of each kept class
    legal.push_back(encodeInstr(5'd0, 2'd0, 5'd0, 5'd3, 3'd2, `opcLoadFp));     // flw
    legal.push_back(encodeInstr(5'd0, 2'd0, 5'd0, 5'd4, 3'd3, `opcLoadFp));     // fld
    legal.push_back(encodeInstr(5'd0, 2'd0, 5'd5, 5'd3, 3'd2, `opcStoreFp));
    legal.push_back(encodeInstr(5'd0, 2'd0, 5'd6, 5'd3, 3'd3, `opcStoreFp));
    legal.push_back(encodeInstr(5'd17, 2'd1, 5'd2, 5'd1, 3'd0, `opcMadd));
    legal.push_back(encodeInstr(5'd18, 2'd0, 5'd2, 5'd1, 3'd1, `opcMsub));
    legal.push_back(encodeInstr(5'd19, 2'd1, 5'd2, 5'd1, 3'd2, `opcNmsub));
    legal.push_back(encodeInstr(5'd20, 2'd0, 5'd2, 5'd1, 3'd3, `opcNmadd));
    legal.push_back(encodeInstr(5'b00000, 2'd0, 5'd8, 5'd9, 3'd7, `opcOpFp));   // fadd
    legal.push_back(encodeInstr(5'b00001, 2'd1, 5'd8, 5'd9, 3'd0, `opcOpFp));
    legal.push_back(encodeInstr(5'b00010, 2'd0, 5'd8, 5'd9, 3'd1, `opcOpFp));   // fmul
    legal.push_back(encodeInstr(5'b00011, 2'd1, 5'd8, 5'd9, 3'd4, `opcOpFp));   // fdiv
    legal.push_back(encodeInstr(5'b01011, 2'd0, 5'd0, 5'd9, 3'd7, `opcOpFp));   // fsqrt
    legal.push_back(encodeInstr(5'b00101, 2'd0, 5'd8, 5'd9, 3'd0, `opcOpFp));   // fmin
    legal.push_back(encodeInstr(5'b00101, 2'd1, 5'd8, 5'd9, 3'd1, `opcOpFp));   // fmax
    legal.push_back(encodeInstr(5'b11100, 2'd0, 5'd0, 5'd9, 3'd0, `opcOpFp));   // fmv.x.w
    legal.push_back(encodeInstr(5'b11100, 2'd1, 5'd0, 5'd9, 3'd1, `opcOpFp));   // fclass
    legal.push_back(encodeInstr(5'b11110, 2'd0, 5'd0, 5'd9, 3'd0, `opcOpFp));   // fmv.w.x
    legal.push_back(encodeInstr(5'b01000, 2'd0, 5'd1, 5'd9, 3'd7, `opcOpFp));   // fcvt.s.d
    legal.push_back(encodeInstr(5'b01000, 2'd1, 5'd0, 5'd9, 3'd0, `opcOpFp));   // fcvt.d.s
    for (int i = 0; i < 3; i++) begin
      legal.push_back(encodeInstr(5'b00100, 2'd0, 5'd2, 5'd1, 3'(i), `opcOpFp)); // sgnj
      legal.push_back(encodeInstr(5'b10100, 2'd1, 5'd2, 5'd1, 3'(i), `opcOpFp)); // compares
    end
    for (int i = 0; i < 4; i++) begin
      legal.push_back(encodeInstr(5'b11010, 2'd0, 5'(i), 5'd3, 3'd7, `opcOpFp)); // int -> fp
      legal.push_back(encodeInstr(5'b11000, 2'd1, 5'(i), 5'd3, 3'd1, `opcOpFp)); // fp -> int
    end
    foreach (legal[i])
      drive(legal[i], 3'b000, 3'b000, 1'b0);
    checkLatency(encodeInstr(5'd0, 2'd0, 5'd0, 5'd0, 3'd0, 7'h7f));          // unknown opcode

    // illegal formats and unlisted funct3
    drive(encodeInstr(5'b00000, 2'd2, 5'd1, 5'd2, 3'd0, `opcOpFp), 3'b000, 3'b000, 1'b0);
    drive(encodeInstr(5'b00010, 2'd3, 5'd1, 5'd2, 3'd0, `opcOpFp), 3'b000, 3'b000, 1'b0);
    drive(encodeInstr(5'b00100, 2'd0, 5'd1, 5'd2, 3'd3, `opcOpFp), 3'b000, 3'b000, 1'b0);
    drive(encodeInstr(5'b10100, 2'd0, 5'd1, 5'd2, 3'd6, `opcOpFp), 3'b000, 3'b000, 1'b0);
    drive(encodeInstr(5'd0, 2'd0, 5'd0, 5'd2, 3'd4, `opcLoadFp), 3'b000, 3'b000, 1'b0);
    writeCsr(3'd3, 2'd0);                                                      // FPU off
    drive(legal[8], 3'b000, 3'b000, 1'b0);
    writeCsr(3'd4, 2'd3);
    drive(legal[8], 3'b000, 3'b000, 1'b0);                                     // dynamic frm
    drive(legal[9], 3'b000, 3'b000, 1'b0);
    drive(legal[11], 3'b100, 3'b000, 1'b1);                                    // stall.e, busy

    // random words, stalls, flushes, busy divider and CSR writes
    repeat (600) begin
      r = $random(seed);
      w = (r[2:0] == 3'd0) ? $random(seed) : legal[r[9:4] % legal.size()];
      drive(w, r[12:10] & r[15:13], r[18:16] & r[21:19] & r[24:22], r[25]);
      if (r[31:28] == 4'd0) begin
        csrWe     <= 1'b1;
        csrWrData <= '{frm: r[26] ? 3'd7 : {1'b0, r[27], r[3]}, fs: r[9] ? 2'd3 : 2'd1};
      end
    end
    drive(32'h0, 3'b000, 3'b111, 1'b0);
    repeat (4) @(posedge clk);   // last compare done on the previous falling edge
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verification/tbClock.sv */
/*
 * testbench clock and reset, 4 ns period
 */
`timescale 1ns/1ns

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;          // released on the third edge
  end

endmodule
